//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_dec
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/dec_op_if.sv
// ----------------------------------------------------------
// one decoded slot from decode to operand stage
// advance and flush are driven from the top level
// ----------------------------------------------------------
`timescale 1ns/1ns

interface dec_op_if;

	logic               valid;   // slot holds an instruction
	dec_pkg::dec_slot_t slot;
	logic               advance; // copy of ex_ready
	logic               flush;

	modport src (
		output valid,
		output slot,
		input  advance,
		input  flush
	);

	modport dst (
		input valid,
		input slot,
		input advance,
		input flush
	);

endinterface

//--- common/dec_pkg.sv
// ----------------------------------------------------------
// shared widths, RV32I opcodes and stage payload types
// NONE encodings are zero so an all-zero slot is inactive
// ----------------------------------------------------------
package dec_pkg;

	localparam int XLEN      = 32;
	localparam int ILEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int RD_IDX_W  = 6;

	// extra msb keeps it away from x0..x31
	localparam logic [RD_IDX_W-1:0] RD_NONE = 6'd32;
	localparam logic [XLEN-1:0]     PC_STEP = 32'd4;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_ALU_IR = 7'b0010011;
	localparam logic [6:0] OP_ALU_RR = 7'b0110011;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

	typedef enum logic [3:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} br_op_t;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE, MEM_HALF, MEM_WORD
	} mem_size_t;

	typedef struct packed {
		logic lui;
		logic auipc;
		logic jal;
		logic jalr;
		logic branch;
		logic load;
		logic store;
		logic alu_ir;
		logic alu_rr;
	} instr_class_t;

	typedef struct packed {
		instr_class_t         cls;
		alu_op_t              alu_op;
		br_op_t               br_op;
		mem_size_t            mem_size;
		logic                 mem_unsigned;
		logic [REG_IDX_W-1:0] rs1;
		logic [REG_IDX_W-1:0] rs2;
		logic [RD_IDX_W-1:0]  rd;
		logic [XLEN-1:0]      imm;
		logic [XLEN-1:0]      pc;
	} dec_slot_t;

	typedef struct packed {
		alu_op_t             alu_op;
		br_op_t              br_op;
		logic                load;
		logic                store;
		mem_size_t           mem_size;
		logic                mem_unsigned;
		logic                jump; // jal or jalr
		logic [XLEN-1:0]     src1;
		logic [XLEN-1:0]     src2;
		logic [XLEN-1:0]     store_data;
		logic [RD_IDX_W-1:0] rd;
		logic [XLEN-1:0]     imm;
		logic [XLEN-1:0]     pc;
	} ex_slot_t;

endpackage

//--- decode/instr_decode.sv
// ----------------------------------------------------------
// RV32I decode stage, one cycle to the slot register
// unknown opcodes give NONE ops and rd RD_NONE
// ----------------------------------------------------------
`timescale 1ns/1ns

module instr_decode (
	input  logic                       cpu_clk,
	input  logic                       cpu_rstn,
	input  logic                       if_valid,
	input  logic [dec_pkg::ILEN-1:0]   instr,
	input  logic [dec_pkg::XLEN-1:0]   pc,
	dec_op_if.src                      op
);

	logic [6:0]               opcode;
	logic [2:0]               fn3;
	logic [6:0]               fn7;
	dec_pkg::instr_class_t    cls;
	dec_pkg::dec_slot_t       slot_d;
	logic                     ir_or_base;
	logic                     use_rd;

	assign opcode = instr[6:0];
	assign fn3    = instr[14:12];
	assign fn7    = instr[31:25];

	assign cls.lui    = (opcode == dec_pkg::OP_LUI);
	assign cls.auipc  = (opcode == dec_pkg::OP_AUIPC);
	assign cls.jal    = (opcode == dec_pkg::OP_JAL);
	assign cls.jalr   = (opcode == dec_pkg::OP_JALR);
	assign cls.branch = (opcode == dec_pkg::OP_BRANCH);
	assign cls.load   = (opcode == dec_pkg::OP_LOAD);
	assign cls.store  = (opcode == dec_pkg::OP_STORE);
	assign cls.alu_ir = (opcode == dec_pkg::OP_ALU_IR);
	assign cls.alu_rr = (opcode == dec_pkg::OP_ALU_RR);

	// immediate forms and base R-type share the funct3 table
	assign ir_or_base = cls.alu_ir || (cls.alu_rr && fn7 == dec_pkg::F7_BASE);
	assign use_rd     = cls.lui || cls.auipc || cls.jal || cls.jalr ||
		cls.load || cls.alu_ir || cls.alu_rr;

	always_comb
	begin
		slot_d          = '0;
		slot_d.cls      = cls;
		slot_d.rs1      = instr[19:15];
		slot_d.rs2      = instr[24:20];
		slot_d.rd       = use_rd ? {1'b0, instr[11:7]} : dec_pkg::RD_NONE;
		slot_d.pc       = pc;

		if (cls.auipc || cls.load || cls.store)
			slot_d.alu_op = dec_pkg::ALU_ADD; // address or pc sum
		else if (cls.branch)
		begin
			case (fn3)
				3'b000, 3'b001: slot_d.alu_op = dec_pkg::ALU_SUB;
				3'b100, 3'b101: slot_d.alu_op = dec_pkg::ALU_SLT;
				3'b110, 3'b111: slot_d.alu_op = dec_pkg::ALU_SLTU;
				default:        slot_d.alu_op = dec_pkg::ALU_NONE;
			endcase
		end
		else if (cls.alu_ir || cls.alu_rr)
		begin
			case (fn3)
				3'b000:
				begin
					if (ir_or_base)
						slot_d.alu_op = dec_pkg::ALU_ADD;
					else if (fn7 == dec_pkg::F7_ALT)
						slot_d.alu_op = dec_pkg::ALU_SUB; // rr only here
				end
				3'b010: if (ir_or_base) slot_d.alu_op = dec_pkg::ALU_SLT;
				3'b011: if (ir_or_base) slot_d.alu_op = dec_pkg::ALU_SLTU;
				3'b100: if (ir_or_base) slot_d.alu_op = dec_pkg::ALU_XOR;
				3'b110: if (ir_or_base) slot_d.alu_op = dec_pkg::ALU_OR;
				3'b111: if (ir_or_base) slot_d.alu_op = dec_pkg::ALU_AND;
				3'b001: if (ir_or_base) slot_d.alu_op = dec_pkg::ALU_SLL;
				default:
				begin
					// 101, shift kind from funct7 for both forms
					if (fn7 == dec_pkg::F7_BASE)
						slot_d.alu_op = dec_pkg::ALU_SRL;
					else if (fn7 == dec_pkg::F7_ALT)
						slot_d.alu_op = dec_pkg::ALU_SRA;
				end
			endcase
		end

		if (cls.branch)
		begin
			case (fn3)
				3'b000:  slot_d.br_op = dec_pkg::BR_EQ;
				3'b001:  slot_d.br_op = dec_pkg::BR_NE;
				3'b100:  slot_d.br_op = dec_pkg::BR_LT;
				3'b101:  slot_d.br_op = dec_pkg::BR_GE;
				3'b110:  slot_d.br_op = dec_pkg::BR_LTU;
				3'b111:  slot_d.br_op = dec_pkg::BR_GEU;
				default: slot_d.br_op = dec_pkg::BR_NONE;
			endcase
		end

		if (cls.load || cls.store)
		begin
			slot_d.mem_size     = dec_pkg::mem_size_t'(fn3[1:0]);
			slot_d.mem_unsigned = fn3[2];
		end

		// sign-extended immediate per format
		if (cls.load || cls.alu_ir || cls.jalr)
			slot_d.imm = {{20{instr[31]}}, instr[31:20]};
		else if (cls.store)
			slot_d.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		else if (cls.branch)
			slot_d.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
		else if (cls.lui || cls.auipc)
			slot_d.imm = {instr[31:12], 12'b0};
		else if (cls.jal)
			slot_d.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
	end

	dec_pipe_reg #(
		.payload_t (dec_pkg::dec_slot_t)
	) u_dec_reg (
		.cpu_clk     (cpu_clk),
		.cpu_rstn    (cpu_rstn),
		.advance     (op.advance),
		.flush       (op.flush),
		.in_valid    (if_valid),
		.in_payload  (slot_d),
		.out_valid   (op.valid),
		.out_payload (op.slot)
	);

endmodule

//--- operand/gprs.sv
// ----------------------------------------------------------
// x1..x31, one write port and two async read ports
// a same-cycle write is bypassed to the reads
// ----------------------------------------------------------
`timescale 1ns/1ns

module gprs (
	input  logic                            cpu_clk,
	input  logic                            cpu_rstn,
	input  logic                            wb_valid,
	input  logic [dec_pkg::REG_IDX_W-1:0]   wb_rd,
	input  logic [dec_pkg::XLEN-1:0]        wb_data,
	input  logic [dec_pkg::REG_IDX_W-1:0]   rs1,
	input  logic [dec_pkg::REG_IDX_W-1:0]   rs2,
	output logic [dec_pkg::XLEN-1:0]        rs1_data,
	output logic [dec_pkg::XLEN-1:0]        rs2_data
);

	logic [dec_pkg::XLEN-1:0] regs [1:31]; // no storage for x0

	function automatic logic [dec_pkg::XLEN-1:0] read_port(
		input logic [dec_pkg::REG_IDX_W-1:0] idx);
		if (idx == '0)
			return '0;
		else if (wb_valid && wb_rd == idx)
			return wb_data; // write-back bypass
		else
			return regs[idx];
	endfunction

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_valid && wb_rd != '0)
		begin
			regs[wb_rd] <= wb_data;
		end
	end

	always_comb
	begin
		rs1_data = read_port(rs1);
	end

	always_comb
	begin
		rs2_data = read_port(rs2);
	end

endmodule

//--- operand/operand_sel.sv
// ----------------------------------------------------------
// operand stage: register read, source select, ex register
// only write-back is bypassed, no EX or MEM forwarding
// ----------------------------------------------------------
`timescale 1ns/1ns

module operand_sel (
	input  logic                            cpu_clk,
	input  logic                            cpu_rstn,
	dec_op_if.dst                           op,
	input  logic                            wb_valid,
	input  logic [dec_pkg::REG_IDX_W-1:0]   wb_rd,
	input  logic [dec_pkg::XLEN-1:0]        wb_data,
	output dec_pkg::ex_slot_t               ex,
	output logic                            ex_valid
);

	logic [dec_pkg::XLEN-1:0] rs1_data;
	logic [dec_pkg::XLEN-1:0] rs2_data;
	dec_pkg::instr_class_t    cls;
	dec_pkg::ex_slot_t        ex_d;
	logic                     use_rs2;
	logic                     use_imm;

	gprs u_gprs (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.rs1      (op.slot.rs1),
		.rs2      (op.slot.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	assign cls     = op.slot.cls;
	assign use_rs2 = cls.alu_rr || cls.branch;                 // R and B
	assign use_imm = cls.load || cls.alu_ir || cls.store ||
		cls.lui || cls.auipc;                                  // I, S, U

	always_comb
	begin
		ex_d              = '0;
		ex_d.alu_op       = op.slot.alu_op;
		ex_d.br_op        = op.slot.br_op;
		ex_d.load         = cls.load;
		ex_d.store        = cls.store;
		ex_d.mem_size     = op.slot.mem_size;
		ex_d.mem_unsigned = op.slot.mem_unsigned;
		ex_d.jump         = cls.jal || cls.jalr;
		ex_d.store_data   = rs2_data;
		ex_d.rd           = op.slot.rd;
		ex_d.imm          = op.slot.imm;
		ex_d.pc           = op.slot.pc;

		if (cls.auipc)
			ex_d.src1 = op.slot.pc;
		else if (cls.lui || cls.jal)
			ex_d.src1 = '0;
		else
			ex_d.src1 = rs1_data; // x0 already reads zero

		if (cls.jal || cls.jalr)
			ex_d.src2 = op.slot.pc + dec_pkg::PC_STEP; // link value
		else if (use_rs2)
			ex_d.src2 = rs2_data;
		else if (use_imm)
			ex_d.src2 = op.slot.imm;
		else
			ex_d.src2 = '0;
	end

	dec_pipe_reg #(
		.payload_t (dec_pkg::ex_slot_t)
	) u_ex_reg (
		.cpu_clk     (cpu_clk),
		.cpu_rstn    (cpu_rstn),
		.advance     (op.advance),
		.flush       (op.flush),
		.in_valid    (op.valid),
		.in_payload  (ex_d),
		.out_valid   (ex_valid),
		.out_payload (ex)
	);

endmodule

//--- tb.f
common/dec_pkg.sv
common/dec_op_if.sv
verilog/dec_pipe_reg.sv
decode/instr_decode.sv
operand/gprs.sv
operand/operand_sel.sv
verilog/dec_top.sv
verif/dec_checker.sv
verif/tb_dec.sv

//--- verif/dec_checker.sv
// ----------------------------------------------------------
// execute side protocol assertions, bound into dec_top
// ----------------------------------------------------------
`timescale 1ns/1ns

module dec_checker (
	input logic                            cpu_clk,
	input logic                            cpu_rstn,
	input logic                            ex_valid,
	input logic                            ex_ready,
	input logic                            flush,
	input dec_pkg::alu_op_t                alu_op,
	input dec_pkg::br_op_t                 br_op,
	input logic                            load,
	input logic                            store,
	input dec_pkg::mem_size_t              mem_size,
	input logic                            mem_unsigned,
	input logic                            jump,
	input logic [dec_pkg::XLEN-1:0]        src1,
	input logic [dec_pkg::XLEN-1:0]        src2,
	input logic [dec_pkg::XLEN-1:0]        store_data,
	input logic [dec_pkg::XLEN-1:0]        imm_ex,
	input logic [dec_pkg::XLEN-1:0]        pc_ex,
	input logic [dec_pkg::RD_IDX_W-1:0]    rd_ex
);

	// a stalled slot holds until execute takes it
	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		ex_valid && !ex_ready && !flush |=> ex_valid && $stable({alu_op, br_op, load,
			store, mem_size, mem_unsigned, jump, src1, src2, store_data, imm_ex,
			pc_ex, rd_ex}))
		else $error("execute outputs changed while stalled");

	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		flush |=> !ex_valid)
		else $error("ex_valid set in the cycle after a flush");

	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		!ex_valid |-> rd_ex == dec_pkg::RD_NONE && alu_op == dec_pkg::ALU_NONE)
		else $error("empty output slot shows an active rd or operation");

endmodule

bind dec_top dec_checker u_checker (.*);

//--- verif/tb_dec.sv
// ------------------------------------------------------------
// random RV32I stream against a register mirror and slot model
// register writes only while the pipeline is empty or for bypass
// ------------------------------------------------------------
`timescale 1ns/1ns

module tb_dec;

	logic                          cpu_clk = 1'b0;
	logic                          cpu_rstn;
	logic                          if_valid;
	logic [31:0]                   instr;
	logic [31:0]                   pc;
	logic                          ex_ready;
	logic                          flush;
	logic                          wb_valid;
	logic [4:0]                    wb_rd;
	logic [31:0]                   wb_data;
	logic                          if_ready;
	logic                          ex_valid;
	dec_pkg::alu_op_t              alu_op;
	dec_pkg::br_op_t               br_op;
	logic                          load;
	logic                          store;
	dec_pkg::mem_size_t            mem_size;
	logic                          mem_unsigned;
	logic                          jump;
	logic [31:0]                   src1;
	logic [31:0]                   src2;
	logic [31:0]                   store_data;
	logic [31:0]                   imm_ex;
	logic [31:0]                   pc_ex;
	logic [5:0]                    rd_ex;

	logic [31:0]                   seed = 32'h5715;
	logic [31:0]                   mirror [0:31];
	dec_pkg::ex_slot_t             exp_q [$]; // slots expected at the execute port
	dec_pkg::ex_slot_t             want;
	logic                          d_valid;   // model of the decode slot
	logic [31:0]                   d_instr;
	logic [31:0]                   d_pc;
	int                            n_out;

	dec_top dut (.*);

	always #5 cpu_clk = ~cpu_clk;

	function automatic logic [31:0] lcg();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// legal encodings of the kept classes or an all-zero word
	function automatic logic [31:0] rand_instr();
		logic [31:0] w;
		logic [31:0] r;
		w = lcg();
		r = lcg();
		case (r[23:16] % 10)
			0: w[6:0] = dec_pkg::OP_LUI;
			1: w[6:0] = dec_pkg::OP_AUIPC;
			2: w[6:0] = dec_pkg::OP_JAL;
			3:
			begin
				w[6:0]   = dec_pkg::OP_JALR;
				w[14:12] = 3'b000;
			end
			4:
			begin
				w[6:0] = dec_pkg::OP_BRANCH;
				if (w[14:13] == 2'b01)
					w[13] = 1'b0; // no funct3 010 or 011
			end
			5:
			begin
				w[6:0] = dec_pkg::OP_LOAD;
				if (w[13:12] == 2'b11 || w[14])
					w[13] = 1'b0;
			end
			6:
			begin
				w[6:0] = dec_pkg::OP_STORE;
				w[14]  = 1'b0;
				if (w[13:12] == 2'b11)
					w[13] = 1'b0;
			end
			7:
			begin
				w[6:0] = dec_pkg::OP_ALU_IR;
				if (w[13:12] == 2'b01)
					w[31:25] = {1'b0, w[30] & w[14], 5'b0}; // slli, srli, srai
			end
			8:
			begin
				w[6:0]   = dec_pkg::OP_ALU_RR;
				w[31:25] = {1'b0, w[30] & (w[12] == w[14]) & !w[13], 5'b0};
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	function automatic dec_pkg::alu_op_t alu_from_f3(input logic [2:0] f3,
		input logic alt, input logic rr);
		case (f3)
			3'd0:    return (rr && alt) ? dec_pkg::ALU_SUB : dec_pkg::ALU_ADD;
			3'd1:    return dec_pkg::ALU_SLL;
			3'd2:    return dec_pkg::ALU_SLT;
			3'd3:    return dec_pkg::ALU_SLTU;
			3'd4:    return dec_pkg::ALU_XOR;
			3'd5:    return alt ? dec_pkg::ALU_SRA : dec_pkg::ALU_SRL;
			3'd6:    return dec_pkg::ALU_OR;
			default: return dec_pkg::ALU_AND;
		endcase
	endfunction

	// expected execute slot with operands from the mirror at capture time
	function automatic dec_pkg::ex_slot_t model_ex(input logic [31:0] w,
		input logic [31:0] p);
		dec_pkg::ex_slot_t e;
		logic [31:0]       imm_i;
		logic [31:0]       imm_s;
		logic [31:0]       imm_b;
		logic [31:0]       imm_u;
		logic [31:0]       imm_j;
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		e            = '0;
		e.pc         = p;
		e.rd         = {1'b0, w[11:7]};
		e.src1       = mirror[w[19:15]];
		e.store_data = mirror[w[24:20]];
		case (w[6:0])
			dec_pkg::OP_LUI:
				e.imm = imm_u;
			dec_pkg::OP_AUIPC:
			begin
				e.imm    = imm_u;
				e.alu_op = dec_pkg::ALU_ADD;
			end
			dec_pkg::OP_JAL:
			begin
				e.imm  = imm_j;
				e.jump = 1'b1;
			end
			dec_pkg::OP_JALR:
			begin
				e.imm  = imm_i;
				e.jump = 1'b1;
			end
			dec_pkg::OP_BRANCH:
			begin
				e.imm = imm_b;
				e.rd  = dec_pkg::RD_NONE;
				case (w[14:13])
					2'b00:   e.alu_op = dec_pkg::ALU_SUB;
					2'b10:   e.alu_op = dec_pkg::ALU_SLT;
					default: e.alu_op = dec_pkg::ALU_SLTU;
				endcase
				case (w[14:12])
					3'b000:  e.br_op = dec_pkg::BR_EQ;
					3'b001:  e.br_op = dec_pkg::BR_NE;
					3'b100:  e.br_op = dec_pkg::BR_LT;
					3'b101:  e.br_op = dec_pkg::BR_GE;
					3'b110:  e.br_op = dec_pkg::BR_LTU;
					default: e.br_op = dec_pkg::BR_GEU;
				endcase
			end
			dec_pkg::OP_LOAD, dec_pkg::OP_STORE:
			begin
				// opcode bit 5 tells store from load
				e.imm          = w[5] ? imm_s : imm_i;
				e.load         = !w[5];
				e.store        = w[5];
				e.rd           = w[5] ? dec_pkg::RD_NONE : e.rd;
				e.alu_op       = dec_pkg::ALU_ADD;
				e.mem_size     = dec_pkg::mem_size_t'(w[13:12]);
				e.mem_unsigned = w[14];
			end
			dec_pkg::OP_ALU_IR, dec_pkg::OP_ALU_RR:
			begin
				e.imm    = w[5] ? 32'h0 : imm_i; // R-type has no immediate
				e.alu_op = alu_from_f3(w[14:12], w[30], w[5]);
			end
			default:
				e.rd = dec_pkg::RD_NONE;
		endcase
		if (w[6:0] == dec_pkg::OP_AUIPC)
			e.src1 = p;
		else if (w[6:0] == dec_pkg::OP_LUI || w[6:0] == dec_pkg::OP_JAL)
			e.src1 = '0;
		if (e.jump)
			e.src2 = p + 32'd4;
		else if (w[6:0] == dec_pkg::OP_BRANCH || w[6:0] == dec_pkg::OP_ALU_RR)
			e.src2 = e.store_data;
		else
			e.src2 = e.imm; // zero for unknown opcodes
		return e;
	endfunction

	// offer one instruction with a few random ex_ready gaps
	task automatic send(input logic [31:0] w);
		logic [31:0] r;
		int          tries;
		r     = lcg();
		tries = 0;
		@(posedge cpu_clk);
		if_valid <= 1'b1;
		instr    <= w;
		pc       <= {r[31:2], 2'b00};
		while (r[17:16] == 2'b00 && tries < 6)
		begin
			ex_ready <= 1'b0;
			@(posedge cpu_clk);
			r = lcg();
			tries++;
		end
		ex_ready <= 1'b1;
	endtask

	task automatic drain();
		int t;
		@(posedge cpu_clk);
		if_valid <= 1'b0;
		ex_ready <= 1'b1;
		t = 0;
		do
		begin
			@(negedge cpu_clk); // model state settled here
			t++;
			assert (t <= 20)
			else
				fail_now("pipeline did not drain within 20 cycles");
		end
		while (exp_q.size() != 0 || d_valid);
	endtask

	task automatic write_burst(input int n);
		logic [31:0] r;
		repeat (n)
		begin
			@(posedge cpu_clk);
			r = lcg();
			wb_valid <= r[20] | r[21];
			wb_rd    <= r[28:24]; // x0 included
			wb_data  <= lcg();
		end
		@(posedge cpu_clk);
		wb_valid <= 1'b0;
	endtask

	task automatic bypass_check(input logic on_rs2);
		logic [31:0] r;
		logic [4:0]  ra;
		logic [4:0]  rb;
		drain();
		r  = lcg();
		ra = (r[20:16] == 5'd0) ? 5'd1 : r[20:16];
		rb = (r[25:21] == 5'd0) ? 5'd2 : r[25:21];
		@(posedge cpu_clk);
		if_valid <= 1'b1;
		instr    <= {dec_pkg::F7_ALT, rb, ra, 3'b000, 5'd7, dec_pkg::OP_ALU_RR};
		pc       <= {r[31:2], 2'b00};
		ex_ready <= 1'b1;
		@(posedge cpu_clk);
		if_valid <= 1'b0;
		// lands on the operand capture edge
		wb_valid <= 1'b1;
		wb_rd    <= on_rs2 ? rb : ra;
		wb_data  <= lcg();
		@(posedge cpu_clk);
		wb_valid <= 1'b0;
		drain();
	endtask

	task automatic flush_check(input logic stall);
		logic [31:0] r;
		drain();
		repeat (2)
		begin
			@(posedge cpu_clk);
			r = lcg();
			if_valid <= 1'b1;
			instr    <= rand_instr();
			pc       <= {r[31:2], 2'b00};
			ex_ready <= 1'b1;
		end
		@(posedge cpu_clk);
		instr    <= rand_instr(); // offered with the flush and lost
		flush    <= 1'b1;
		ex_ready <= !stall;
		@(posedge cpu_clk);
		flush    <= 1'b0;
		if_valid <= 1'b0;
		ex_ready <= 1'b1;
		drain();
	endtask

	always @(posedge cpu_clk)
	begin
		if (cpu_rstn)
		begin
			check_val("if_ready", if_ready, ex_ready);
			check_val("ex_valid", ex_valid, exp_q.size() != 0);
			if (ex_valid)
			begin
				want = exp_q[0];
				check_val("alu_op", alu_op, want.alu_op);
				check_val("br_op", br_op, want.br_op);
				check_val("load", load, want.load);
				check_val("store", store, want.store);
				check_val("mem_size", mem_size, want.mem_size);
				check_val("mem_unsigned", mem_unsigned, want.mem_unsigned);
				check_val("jump", jump, want.jump);
				check_val("src1", src1, want.src1);
				check_val("src2", src2, want.src2);
				check_val("store_data", store_data, want.store_data);
				check_val("imm_ex", imm_ex, want.imm);
				check_val("pc_ex", pc_ex, want.pc);
				check_val("rd_ex", rd_ex, want.rd);
				if (ex_ready)
				begin
					void'(exp_q.pop_front());
					n_out++;
				end
			end
			else
			begin
				// empty slot shows inactive controls
				check_val("alu_op", alu_op, dec_pkg::ALU_NONE);
				check_val("br_op", br_op, dec_pkg::BR_NONE);
				check_val("load", load, 1'b0);
				check_val("store", store, 1'b0);
				check_val("jump", jump, 1'b0);
				check_val("rd_ex", rd_ex, dec_pkg::RD_NONE);
			end
			if (wb_valid && wb_rd != 5'd0)
				mirror[wb_rd] = wb_data; // also what the bypass returns
			if (flush)
			begin
				exp_q.delete();
				d_valid = 1'b0;
			end
			else if (ex_ready)
			begin
				if (d_valid)
					exp_q.push_back(model_ex(d_instr, d_pc));
				d_valid = if_valid;
				d_instr = instr;
				d_pc    = pc;
			end
		end
	end

	initial
	begin
		cpu_rstn = 1'b0;
		if_valid = 1'b0;
		instr    = '0;
		pc       = '0;
		ex_ready = 1'b0;
		flush    = 1'b0;
		wb_valid = 1'b0;
		wb_rd    = '0;
		wb_data  = '0;
		d_valid  = 1'b0;
		d_instr  = '0;
		d_pc     = '0;
		n_out    = 0;
		for (int i = 0; i < 32; i++)
			mirror[i] = '0;
		repeat (5) @(posedge cpu_clk);
		cpu_rstn <= 1'b1;
		write_burst(40);
		for (int i = 0; i < 300; i++)
		begin
			if (i % 60 == 59)
			begin
				drain();
				write_burst(16);
			end
			send(rand_instr());
		end
		drain();
		for (int k = 0; k < 8; k++)
			bypass_check(k[0]);
		flush_check(1'b0);
		flush_check(1'b1);
		for (int i = 0; i < 40; i++)
			send(rand_instr());
		drain();
		// 300 random, 8 bypass, 1 taken at the flush edge, 40 after the flushes
		assert (n_out == 349)
			$display("TEST RESULT: PASS");
		else
			fail_now("wrong number of instructions reached the execute port");
		$finish;
	end

endmodule

//--- verilog/dec_pipe_reg.sv
// ----------------------------------------------------------
// one pipeline slot with valid, hold on !advance
// an empty slot holds the all-zero payload
// ----------------------------------------------------------
`timescale 1ns/1ns

module dec_pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     cpu_clk,
	input  logic     cpu_rstn,
	input  logic     advance,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     out_valid,
	output payload_t out_payload
);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			out_valid   <= 1'b0;
			out_payload <= '0;
		end
		else if (flush)
		begin
			out_valid   <= 1'b0; // offered slot is dropped too
			out_payload <= '0;
		end
		else if (advance)
		begin
			out_valid   <= in_valid;
			out_payload <= in_valid ? in_payload : '0;
		end
	end

endmodule

//--- verilog/dec_top.sv
// ----------------------------------------------------------
// two-stage decode top, plain ports toward fetch and execute
// if_ready is ex_ready, flush kills both stages
// ----------------------------------------------------------
`timescale 1ns/1ns

module dec_top (
	input  logic                            cpu_clk,
	input  logic                            cpu_rstn,
	input  logic                            if_valid,
	input  logic [dec_pkg::ILEN-1:0]        instr,
	input  logic [dec_pkg::XLEN-1:0]        pc,
	input  logic                            ex_ready,
	input  logic                            flush,
	input  logic                            wb_valid,
	input  logic [dec_pkg::REG_IDX_W-1:0]   wb_rd,
	input  logic [dec_pkg::XLEN-1:0]        wb_data,
	output logic                            if_ready,
	output logic                            ex_valid,
	output dec_pkg::alu_op_t                alu_op,
	output dec_pkg::br_op_t                 br_op,
	output logic                            load,
	output logic                            store,
	output dec_pkg::mem_size_t              mem_size,
	output logic                            mem_unsigned,
	output logic                            jump,
	output logic [dec_pkg::XLEN-1:0]        src1,
	output logic [dec_pkg::XLEN-1:0]        src2,
	output logic [dec_pkg::XLEN-1:0]        store_data,
	output logic [dec_pkg::XLEN-1:0]        imm_ex,
	output logic [dec_pkg::XLEN-1:0]        pc_ex,
	output logic [dec_pkg::RD_IDX_W-1:0]    rd_ex
);

	dec_op_if          u_op ();
	dec_pkg::ex_slot_t ex;

	assign u_op.advance = ex_ready; // global back-pressure
	assign u_op.flush   = flush;
	assign if_ready     = ex_ready;

	instr_decode u_decode (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.if_valid (if_valid),
		.instr    (instr),
		.pc       (pc),
		.op       (u_op)
	);

	operand_sel u_operand (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.op       (u_op),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.ex       (ex),
		.ex_valid (ex_valid)
	);

	assign alu_op       = ex.alu_op;
	assign br_op        = ex.br_op;
	assign load         = ex.load;
	assign store        = ex.store;
	assign mem_size     = ex.mem_size;
	assign mem_unsigned = ex.mem_unsigned;
	assign jump         = ex.jump;
	assign src1         = ex.src1;
	assign src2         = ex.src2;
	assign store_data   = ex.store_data;
	assign imm_ex       = ex.imm;
	assign pc_ex        = ex.pc;
	// empty slot is all zero, so map its rd to RD_NONE
	assign rd_ex        = ex_valid ? ex.rd : dec_pkg::RD_NONE;

endmodule
